// ==== fifo_data_pkg.sv ====
package fifo_data_pkg;

  // Word and bank geometry
  localparam int DWIDTH = 32;
  localparam int BANK_DEPTH = 4;

  // Per-bank occupancy where half_full turns on
  localparam int BANK_HALF = 2;

  // One stored word
  typedef logic [DWIDTH-1:0] data_t;

  // Bank occupancy, 0 up to BANK_DEPTH inclusive
  typedef logic [$clog2(BANK_DEPTH+1)-1:0] bank_cnt_t;

  // Read or write slot inside a bank, wraps at BANK_DEPTH
  typedef logic [$clog2(BANK_DEPTH)-1:0] bank_ptr_t;

endpackage

// ==== lane_pkg.sv ====
package lane_pkg;

  // One bank per push lane
  localparam int NUM_LANES = 4;

  // Start pointer, names the bank that takes the next entry
  typedef logic [$clog2(NUM_LANES)-1:0] lane_id_t;

  // One bit per bank or per push lane
  typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

// ==== bank_if.sv ====
`timescale 1ns/1ps

interface bank_if
  import fifo_data_pkg::*;
();

  // Driven by the steering blocks
  logic push;
  data_t in_data;
  logic pop;

  // Driven by the bank
  data_t out_data;
  logic full;
  logic empty;
  logic half_full;
  logic idle;

  modport bank (
    input push,
    input in_data,
    input pop,
    output out_data,
    output full,
    output empty,
    output half_full,
    output idle
  );

  modport writer (
    output push,
    output in_data
  );

  modport reader (
    output pop,
    input out_data
  );

  modport monitor (
    input full,
    input empty,
    input half_full,
    input idle
  );

endinterface

// ==== fifo_bank.sv ====
`timescale 1ns/1ps

module fifo_bank
  import fifo_data_pkg::*;
(
  input logic clk,
  input logic reset,
  bank_if.bank bif
);

  data_t mem [BANK_DEPTH];
  bank_ptr_t wr_ptr;
  bank_ptr_t rd_ptr;
  bank_cnt_t count;
  logic is_full;
  logic is_empty;
  logic do_push;
  logic do_pop;

  assign is_full = (count == bank_cnt_t'(BANK_DEPTH));
  assign is_empty = (count == '0);

  // Push into a full bank is dropped, pop from an empty one ignored
  assign do_push = bif.push && !is_full;
  assign do_pop = bif.pop && !is_empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= bif.in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + bank_ptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + bank_ptr_t'(1);
      end
      case ({do_push, do_pop})
        2'b10: count <= count + bank_cnt_t'(1);
        2'b01: count <= count - bank_cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

  // Head word, stale when empty
  assign bif.out_data = mem[rd_ptr];

  assign bif.full = is_full;
  assign bif.empty = is_empty;
  assign bif.half_full = (count >= bank_cnt_t'(BANK_HALF));
  assign bif.idle = is_empty && !bif.push;

endmodule

// ==== push_steer.sv ====
`timescale 1ns/1ps

module push_steer
  import fifo_data_pkg::*;
  import lane_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic push0,
  input logic push1,
  input logic push2,
  input logic push3,
  input data_t in_data0,
  input data_t in_data1,
  input data_t in_data2,
  input data_t in_data3,
  bank_if.writer banks [NUM_LANES]
);

  lane_id_t start_id;
  lane_id_t push_adv;
  lane_mask_t push_mask;
  lane_mask_t bank_push;
  data_t [NUM_LANES-1:0] lane_data;
  data_t [NUM_LANES-1:0] bank_data;

  assign push_mask = {push3, push2, push1, push0};
  assign lane_data = {in_data3, in_data2, in_data1, in_data0};

  // Four pushes wrap back to the same start bank
  assign push_adv = lane_id_t'($countones(push_mask));

  always_ff @(posedge clk) begin
    if (reset) begin
      start_id <= '0;
    end else if (|push_mask) begin
      start_id <= start_id + push_adv;
    end
  end

  // Lane k lands on bank start + k
  always_comb begin
    case (start_id)
      2'd1: begin
        bank_push = {push_mask[2:0], push_mask[3]};
        bank_data = {lane_data[2:0], lane_data[3]};
      end
      2'd2: begin
        bank_push = {push_mask[1:0], push_mask[3:2]};
        bank_data = {lane_data[1:0], lane_data[3:2]};
      end
      2'd3: begin
        bank_push = {push_mask[0], push_mask[3:1]};
        bank_data = {lane_data[0], lane_data[3:1]};
      end
      default: begin
        bank_push = push_mask;
        bank_data = lane_data;
      end
    endcase
  end

  for (genvar b = 0; b < NUM_LANES; b++) begin : g_bank
    assign banks[b].push = bank_push[b];
    assign banks[b].in_data = bank_data[b];
  end

endmodule

// ==== pop_steer.sv ====
`timescale 1ns/1ps

module pop_steer
  import fifo_data_pkg::*;
  import lane_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic pop0,
  input logic pop1,
  bank_if.reader banks [NUM_LANES],
  output data_t out_data0,
  output data_t out_data1
);

  lane_id_t start_id;
  lane_id_t pop_adv;
  lane_mask_t bank_pop;
  data_t [NUM_LANES-1:0] head;

  // Either one or two pops per cycle
  assign pop_adv = lane_id_t'(pop0) + lane_id_t'(pop1);

  always_ff @(posedge clk) begin
    if (reset) begin
      start_id <= '0;
    end else if (pop0 || pop1) begin
      start_id <= start_id + pop_adv;
    end
  end

  always_comb begin
    case (start_id)
      2'd1: begin
        bank_pop = {1'b0, pop1, pop0, 1'b0};
        out_data0 = head[1];
        out_data1 = head[2];
      end
      2'd2: begin
        bank_pop = {pop1, pop0, 2'b00};
        out_data0 = head[2];
        out_data1 = head[3];
      end
      2'd3: begin
        bank_pop = {pop0, 2'b00, pop1};
        out_data0 = head[3];
        out_data1 = head[0];
      end
      default: begin
        bank_pop = {2'b00, pop1, pop0};
        out_data0 = head[0];
        out_data1 = head[1];
      end
    endcase
  end

  for (genvar b = 0; b < NUM_LANES; b++) begin : g_bank
    assign banks[b].pop = bank_pop[b];
    assign head[b] = banks[b].out_data;
  end

endmodule

// ==== fifo_status.sv ====
`timescale 1ns/1ps

module fifo_status
  import fifo_data_pkg::*;
  import lane_pkg::*;
(
  bank_if.monitor banks [NUM_LANES],
  output logic full,
  output logic one_left_to_full,
  output logic two_left_to_full,
  output logic three_left_to_full,
  output logic half_full,
  output logic empty,
  output logic one_left_to_empty,
  output logic idle
);

  lane_mask_t bank_full;
  lane_mask_t bank_empty;
  lane_mask_t bank_half;
  lane_mask_t bank_idle;
  bank_cnt_t full_cnt;
  bank_cnt_t busy_cnt;

  for (genvar b = 0; b < NUM_LANES; b++) begin : g_bank
    assign bank_full[b] = banks[b].full;
    assign bank_empty[b] = banks[b].empty;
    assign bank_half[b] = banks[b].half_full;
    assign bank_idle[b] = banks[b].idle;
  end

  // Banks stay within one entry of each other, so full banks give the count
  assign full_cnt = bank_cnt_t'($countones(bank_full));
  assign busy_cnt = bank_cnt_t'($countones(~bank_empty));

  assign full = (full_cnt == bank_cnt_t'(4));
  assign one_left_to_full = (full_cnt == bank_cnt_t'(3));
  assign two_left_to_full = (full_cnt == bank_cnt_t'(2));
  assign three_left_to_full = (full_cnt == bank_cnt_t'(1));

  assign half_full = &bank_half;
  assign empty = &bank_empty;
  assign idle = &bank_idle;

  // Single stored entry
  assign one_left_to_empty = (busy_cnt == bank_cnt_t'(1)) && (full_cnt == '0);

endmodule

// ==== wide_fifo_4w2r.sv ====
`timescale 1ns/1ps

module wide_fifo_4w2r
  import fifo_data_pkg::*;
  import lane_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic push0,
  input logic push1,
  input logic push2,
  input logic push3,
  input data_t in_data0,
  input data_t in_data1,
  input data_t in_data2,
  input data_t in_data3,
  input logic pop0,
  input logic pop1,
  output data_t out_data0,
  output data_t out_data1,
  output logic full,
  output logic one_left_to_full,
  output logic two_left_to_full,
  output logic three_left_to_full,
  output logic half_full,
  output logic empty,
  output logic one_left_to_empty,
  output logic idle
);

  bank_if bif [NUM_LANES] ();

  push_steer u_push (
    .clk (clk),
    .reset (reset),
    .push0 (push0),
    .push1 (push1),
    .push2 (push2),
    .push3 (push3),
    .in_data0 (in_data0),
    .in_data1 (in_data1),
    .in_data2 (in_data2),
    .in_data3 (in_data3),
    .banks (bif)
  );

  pop_steer u_pop (
    .clk (clk),
    .reset (reset),
    .pop0 (pop0),
    .pop1 (pop1),
    .banks (bif),
    .out_data0 (out_data0),
    .out_data1 (out_data1)
  );

  // Bank b holds stream entries b, b+4, b+8 and b+12
  for (genvar b = 0; b < NUM_LANES; b++) begin : g_bank
    fifo_bank u_bank (
      .clk (clk),
      .reset (reset),
      .bif (bif[b])
    );
  end

  fifo_status u_status (
    .banks (bif),
    .full (full),
    .one_left_to_full (one_left_to_full),
    .two_left_to_full (two_left_to_full),
    .three_left_to_full (three_left_to_full),
    .half_full (half_full),
    .empty (empty),
    .one_left_to_empty (one_left_to_empty),
    .idle (idle)
  );

endmodule

// ==== tb_wide_fifo.sv ====
`timescale 1ns/1ps

module tb_wide_fifo
  import fifo_data_pkg::*;
();

  localparam int HALF_PERIOD = 50;
  localparam int SAMPLE_LEAD = 10;
  localparam int RESET_TIMEOUT = 8;
  localparam int MAX_LINES = 200;

  logic clk;
  logic reset;
  logic push0;
  logic push1;
  logic push2;
  logic push3;
  data_t in_data0;
  data_t in_data1;
  data_t in_data2;
  data_t in_data3;
  logic pop0;
  logic pop1;
  data_t out_data0;
  data_t out_data1;
  logic full;
  logic one_left_to_full;
  logic two_left_to_full;
  logic three_left_to_full;
  logic half_full;
  logic empty;
  logic one_left_to_empty;
  logic idle;

  int fd;
  int status;
  int line_no;
  int lines_checked;
  int wait_cycles;
  string line;
  logic [3:0] mask;
  data_t d0;
  data_t d1;
  data_t d2;
  data_t d3;
  data_t exp0;
  data_t exp1;
  int pops;
  int nvalid;
  logic [7:0] exp_flags;

  wide_fifo_4w2r dut0 (
    .clk (clk),
    .reset (reset),
    .push0 (push0),
    .push1 (push1),
    .push2 (push2),
    .push3 (push3),
    .in_data0 (in_data0),
    .in_data1 (in_data1),
    .in_data2 (in_data2),
    .in_data3 (in_data3),
    .pop0 (pop0),
    .pop1 (pop1),
    .out_data0 (out_data0),
    .out_data1 (out_data1),
    .full (full),
    .one_left_to_full (one_left_to_full),
    .two_left_to_full (two_left_to_full),
    .three_left_to_full (three_left_to_full),
    .half_full (half_full),
    .empty (empty),
    .one_left_to_empty (one_left_to_empty),
    .idle (idle)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "testbench stopped at golden line %0d", line_no);
  endtask

  task automatic check_word(input string name, input data_t expected, input data_t actual);
    assert (actual === expected)
    else begin
      abort_run($sformatf("Mismatch %s expected 0x%h got 0x%h (golden line %0d)",
                          name, expected, actual, line_no));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    assert (actual === expected)
    else begin
      abort_run($sformatf("Mismatch %s expected 0x%h got 0x%h (golden line %0d)",
                          name, expected, actual, line_no));
    end
  endtask

  task automatic drive_inputs(input logic [3:0] lanes, input data_t w0, input data_t w1,
                              input data_t w2, input data_t w3, input int pop_count);
    push0 = lanes[0];
    push1 = lanes[1];
    push2 = lanes[2];
    push3 = lanes[3];
    in_data0 = w0;
    in_data1 = w1;
    in_data2 = w2;
    in_data3 = w3;
    pop0 = (pop_count >= 1);
    pop1 = (pop_count >= 2);
  endtask

  // Read words beyond the stored count are stale
  task automatic compare_outputs(input int valid_words, input data_t w0, input data_t w1,
                                 input logic [7:0] flags);
    if (valid_words >= 1) begin
      check_word("out_data0", w0, out_data0);
    end
    if (valid_words >= 2) begin
      check_word("out_data1", w1, out_data1);
    end
    check_flag("full", flags[7], full);
    check_flag("one_left_to_full", flags[6], one_left_to_full);
    check_flag("two_left_to_full", flags[5], two_left_to_full);
    check_flag("three_left_to_full", flags[4], three_left_to_full);
    check_flag("half_full", flags[3], half_full);
    check_flag("empty", flags[2], empty);
    check_flag("one_left_to_empty", flags[1], one_left_to_empty);
    check_flag("idle", flags[0], idle);
  endtask

  initial begin
    reset = 1'b1;
    drive_inputs(4'h0, '0, '0, '0, '0, 0);
    line_no = 0;
    lines_checked = 0;

    fd = $fopen("wide_fifo_golden.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open wide_fifo_golden.txt for reading");
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    wait_cycles = 0;
    while (empty !== 1'b1) begin
      if (wait_cycles >= RESET_TIMEOUT) begin
        abort_run("Timeout: the FIFO never reported empty after reset");
      end
      @(negedge clk);
      wait_cycles++;
    end

    // One golden line per clock cycle
    while (!$feof(fd)) begin
      if (line_no >= MAX_LINES) begin
        abort_run("Timeout: golden file still not finished after the line limit");
      end
      line_no++;
      status = $fgets(line, fd);
      if (status == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      status = $sscanf(line, "%h %h %h %h %h %d %d %h %h %b", mask, d0, d1, d2, d3,
                       pops, nvalid, exp0, exp1, exp_flags);
      if (status != 10) begin
        abort_run($sformatf("Golden line %0d could not be parsed", line_no));
      end
      drive_inputs(mask, d0, d1, d2, d3, pops);
      #(HALF_PERIOD - SAMPLE_LEAD);
      compare_outputs(nvalid, exp0, exp1, exp_flags);
      lines_checked++;
      @(posedge clk);
      @(negedge clk);
    end
    $fclose(fd);

    if (lines_checked > 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("The golden file held no stimulus lines");
    end
  end

endmodule

// ==== wide_fifo_golden.txt ====
# push_mask in_data0 in_data1 in_data2 in_data3 pop_count valid_words exp_out0 exp_out1 flags
# flags: full one_left_to_full two_left_to_full three_left_to_full half_full empty one_left_to_empty idle
0 deadbeef deadbeef deadbeef deadbeef 0 0 00000000 00000000 00000101
1 10000001 deadbeef deadbeef deadbeef 0 0 00000000 00000000 00000100
1 10000002 deadbeef deadbeef deadbeef 0 1 10000001 00000000 00000010
1 10000003 deadbeef deadbeef deadbeef 0 2 10000001 10000002 00000000
0 deadbeef deadbeef deadbeef deadbeef 1 2 10000001 10000002 00000000
0 deadbeef deadbeef deadbeef deadbeef 1 2 10000002 10000003 00000000
0 deadbeef deadbeef deadbeef deadbeef 1 1 10000003 00000000 00000010
0 deadbeef deadbeef deadbeef deadbeef 0 0 00000000 00000000 00000101
3 10000004 10000005 deadbeef deadbeef 0 0 00000000 00000000 00000100
7 10000006 10000007 10000008 deadbeef 0 2 10000004 10000005 00000000
f 10000009 1000000a 1000000b 1000000c 2 2 10000004 10000005 00000000
1 1000000d deadbeef deadbeef deadbeef 2 2 10000006 10000007 00000000
3 1000000e 1000000f deadbeef deadbeef 2 2 10000008 10000009 00000000
7 10000010 10000011 10000012 deadbeef 2 2 1000000a 1000000b 00000000
0 deadbeef deadbeef deadbeef deadbeef 2 2 1000000c 1000000d 00000000
f 10000013 10000014 10000015 10000016 1 2 1000000e 1000000f 00000000
0 deadbeef deadbeef deadbeef deadbeef 2 2 1000000f 10000010 00001000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000011 10000012 00000000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000013 10000014 00000000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000015 10000016 00000000
0 deadbeef deadbeef deadbeef deadbeef 0 0 00000000 00000000 00000101
f 10000017 10000018 10000019 1000001a 0 0 00000000 00000000 00000100
f 1000001b 1000001c 1000001d 1000001e 0 2 10000017 10000018 00000000
7 1000001f 10000020 10000021 deadbeef 0 2 10000017 10000018 00001000
3 10000022 10000023 deadbeef deadbeef 0 2 10000017 10000018 00001000
1 10000024 deadbeef deadbeef deadbeef 0 2 10000017 10000018 00011000
1 10000025 deadbeef deadbeef deadbeef 0 2 10000017 10000018 00101000
1 10000026 deadbeef deadbeef deadbeef 0 2 10000017 10000018 01001000
0 deadbeef deadbeef deadbeef deadbeef 0 2 10000017 10000018 10001000
0 deadbeef deadbeef deadbeef deadbeef 1 2 10000017 10000018 10001000
1 10000027 deadbeef deadbeef deadbeef 1 2 10000018 10000019 01001000
1 10000028 deadbeef deadbeef deadbeef 2 2 10000019 1000001a 01001000
3 10000029 1000002a deadbeef deadbeef 1 2 1000001b 1000001c 00101000
1 1000002b deadbeef deadbeef deadbeef 0 2 1000001c 1000001d 01001000
0 deadbeef deadbeef deadbeef deadbeef 2 2 1000001c 1000001d 10001000
0 deadbeef deadbeef deadbeef deadbeef 2 2 1000001e 1000001f 00101000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000020 10000021 00001000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000022 10000023 00001000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000024 10000025 00001000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000026 10000027 00000000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000028 10000029 00000000
0 deadbeef deadbeef deadbeef deadbeef 1 2 1000002a 1000002b 00000000
0 deadbeef deadbeef deadbeef deadbeef 0 1 1000002b 00000000 00000010
0 deadbeef deadbeef deadbeef deadbeef 1 1 1000002b 00000000 00000010
0 deadbeef deadbeef deadbeef deadbeef 0 0 00000000 00000000 00000101
1 1000002c deadbeef deadbeef deadbeef 0 0 00000000 00000000 00000100
0 deadbeef deadbeef deadbeef deadbeef 1 1 1000002c 00000000 00000010
3 1000002d 1000002e deadbeef deadbeef 0 0 00000000 00000000 00000100
1 1000002f deadbeef deadbeef deadbeef 1 2 1000002d 1000002e 00000000
f 10000030 10000031 10000032 10000033 2 2 1000002e 1000002f 00000000
0 deadbeef deadbeef deadbeef deadbeef 2 2 10000030 10000031 00000000
1 10000034 deadbeef deadbeef deadbeef 2 2 10000032 10000033 00000000
0 deadbeef deadbeef deadbeef deadbeef 1 1 10000034 00000000 00000010
0 deadbeef deadbeef deadbeef deadbeef 0 0 00000000 00000000 00000101

// ==== filelist.f ====
fifo_data_pkg.sv
lane_pkg.sv
bank_if.sv
fifo_bank.sv
push_steer.sv
pop_steer.sv
fifo_status.sv
wide_fifo_4w2r.sv
tb_wide_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the wide FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/sim_tb_wide_fifo

rm -rf obj_dir "$LOG"

verilator --binary --timing -f filelist.f --top-module tb_wide_fifo -o sim_tb_wide_fifo
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Regression passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
